// File: gat_layer.f
src/gat_dim_pkg.sv
src/gat_ctrl_pkg.sv
src/gat_ctrl_fsm.sv
src/node_counter.sv
src/wh_engine.sv
src/attn_score.sv
src/aggregator.sv
src/gat_layer_top.sv
tb/gat_layer_props.sv
tb/tb_gat_layer.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_gat_layer \
  -f gat_layer.f \
  -o sim_gat_layer

./obj_dir/sim_gat_layer 2>&1 | tee sim.log

if grep -q "TEST FAIL" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi

echo "Simulation finished without a reported failure"

// File: src/aggregator.sv
`timescale 1ns/1ps

module aggregator (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      clear_i,
  input  gat_dim_pkg::score_beat_t  beat_i,
  output gat_dim_pkg::out_vec_t     feat_o
);

  gat_dim_pkg::out_vec_t acc;
  gat_dim_pkg::out_vec_t prod;

  // Score times each element of the neighbour product
  always_comb begin
    prod = '0;
    for (int o = 0; o < gat_dim_pkg::NUM_FEAT_OUT; o++) begin
      prod[o] = $signed(beat_i.score) * $signed(beat_i.wh[o]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc <= '0;
    end else if (clear_i) begin
      acc <= '0;
    end else if (beat_i.valid) begin
      for (int o = 0; o < gat_dim_pkg::NUM_FEAT_OUT; o++) begin
        acc[o] <= acc[o] + prod[o];
      end
    end
  end

  // Holds the last result until the next clear
  assign feat_o = acc;

endmodule

// File: src/attn_score.sv
`timescale 1ns/1ps

module attn_score (
  input  logic                      clk,
  input  logic                      rst_n,
  input  gat_dim_pkg::attn_vec_t    attn_i,
  input  logic                      issue_i,
  input  gat_dim_pkg::wh_vec_t      wh_center_i,
  input  gat_dim_pkg::wh_vec_t      wh_sel_i,
  output gat_dim_pkg::score_beat_t  beat_o
);

  logic signed [gat_dim_pkg::SCORE_W-1:0] raw_sum;
  gat_dim_pkg::score_t                    score_act;

  logic                 beat_vld;
  gat_dim_pkg::score_t  beat_score;
  gat_dim_pkg::wh_vec_t beat_wh;

  // a^T [Wh_center || Wh_neighbour]
  always_comb begin
    raw_sum = '0;
    for (int i = 0; i < gat_dim_pkg::NUM_FEAT_OUT; i++) begin
      raw_sum = raw_sum
              + $signed(attn_i[i]) * $signed(wh_center_i[i])
              + $signed(attn_i[i+gat_dim_pkg::NUM_FEAT_OUT]) * $signed(wh_sel_i[i]);
    end
  end

  // Leaky ReLU with a negative slope of 1/8
  assign score_act = raw_sum[gat_dim_pkg::SCORE_W-1] ?
                     (raw_sum >>> gat_dim_pkg::LRELU_SHIFT) : raw_sum;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_vld <= 1'b0;
    end else begin
      beat_vld <= issue_i;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_i) begin
      beat_score <= score_act;
      beat_wh    <= wh_sel_i;
    end
  end

  assign beat_o = '{valid: beat_vld, score: beat_score, wh: beat_wh};

endmodule

// File: src/gat_ctrl_fsm.sv
`timescale 1ns/1ps

module gat_ctrl_fsm (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start_i,
  input  logic                    node_vld_i,
  input  logic                    last_node_i,
  output gat_ctrl_pkg::ctrl_cmd_t cmd_o,
  output logic                    busy_o,
  output logic                    done_o
);

  gat_ctrl_pkg::gat_state_e state;
  gat_ctrl_pkg::gat_state_e state_nxt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= gat_ctrl_pkg::IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      gat_ctrl_pkg::IDLE: begin
        if (start_i) begin
          state_nxt = gat_ctrl_pkg::LOAD;
        end
      end
      gat_ctrl_pkg::LOAD: begin
        // Last strobe ends the load phase
        if (node_vld_i && last_node_i) begin
          state_nxt = gat_ctrl_pkg::SCORE;
        end
      end
      gat_ctrl_pkg::SCORE: begin
        if (last_node_i) begin
          state_nxt = gat_ctrl_pkg::DRAIN;
        end
      end
      gat_ctrl_pkg::DRAIN: begin
        state_nxt = gat_ctrl_pkg::DONE;
      end
      gat_ctrl_pkg::DONE: begin
        state_nxt = gat_ctrl_pkg::IDLE;
      end
      default: begin
        state_nxt = gat_ctrl_pkg::IDLE;
      end
    endcase
  end

  // Command decode
  always_comb begin
    cmd_o          = '0;
    cmd_o.load_en  = (state == gat_ctrl_pkg::LOAD);
    cmd_o.score_en = (state == gat_ctrl_pkg::SCORE);
    // Only a start taken in IDLE clears the datapath
    cmd_o.clear    = (state == gat_ctrl_pkg::IDLE) && start_i;
    cmd_o.finish   = (state == gat_ctrl_pkg::DONE);
  end

  assign busy_o = (state != gat_ctrl_pkg::IDLE);
  assign done_o = cmd_o.finish;

endmodule

// File: src/gat_ctrl_pkg.sv
package gat_ctrl_pkg;

  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    SCORE,
    DRAIN,
    DONE
  } gat_state_e;

  // Per-cycle command from the sequencer
  typedef struct packed {
    logic load_en;
    logic score_en;
    logic clear;
    logic finish;
  } ctrl_cmd_t;

endpackage

// File: src/gat_dim_pkg.sv
package gat_dim_pkg;

  // Layer sizes
  localparam int NUM_FEAT_IN  = 4;
  localparam int NUM_FEAT_OUT = 2;
  localparam int MAX_NODES    = 4;
  localparam int NODE_IDX_W   = 2;

  // Element widths
  localparam int DATA_W      = 8;
  localparam int WH_W        = 18;
  localparam int SCORE_W     = 28;
  localparam int ACC_W       = 48;
  localparam int LRELU_SHIFT = 3;

  // Named signed element types keep packed array elements signed
  typedef logic signed [DATA_W-1:0]  data_t;
  typedef logic signed [WH_W-1:0]    wh_t;
  typedef logic signed [SCORE_W-1:0] score_t;
  typedef logic signed [ACC_W-1:0]   acc_t;

  typedef data_t [NUM_FEAT_IN-1:0]                      feat_vec_t;
  typedef data_t [NUM_FEAT_OUT-1:0][NUM_FEAT_IN-1:0]    weight_mat_t;
  // Lower half weights the centre product, upper half the neighbour
  typedef data_t [2*NUM_FEAT_OUT-1:0]                   attn_vec_t;
  typedef wh_t   [NUM_FEAT_OUT-1:0]                     wh_vec_t;
  typedef acc_t  [NUM_FEAT_OUT-1:0]                     out_vec_t;

  typedef struct packed {
    logic    valid;
    score_t  score;
    wh_vec_t wh;
  } score_beat_t;

endpackage

// File: src/gat_layer_top.sv
`timescale 1ns/1ps

module gat_layer_top (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              start_i,
  input  logic [gat_dim_pkg::NODE_IDX_W:0]  num_nodes_i,
  input  gat_dim_pkg::weight_mat_t          wgt_i,
  input  gat_dim_pkg::attn_vec_t            attn_i,
  input  logic                              node_vld_i,
  input  gat_dim_pkg::feat_vec_t            node_feat_i,
  output logic                              busy_o,
  output logic                              done_o,
  output gat_dim_pkg::out_vec_t             feat_o
);

  gat_ctrl_pkg::ctrl_cmd_t             cmd;
  logic [gat_dim_pkg::NODE_IDX_W-1:0]  node_idx;
  logic                                last_node;
  logic                                wh_wr_en;
  gat_dim_pkg::wh_vec_t                wh_center;
  gat_dim_pkg::wh_vec_t                wh_sel;
  gat_dim_pkg::score_beat_t            beat;

  // Strobes count only while loading
  assign wh_wr_en = cmd.load_en && node_vld_i;

  gat_ctrl_fsm u_ctrl_fsm (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .node_vld_i  (node_vld_i),
    .last_node_i (last_node),
    .cmd_o       (cmd),
    .busy_o      (busy_o),
    .done_o      (done_o)
  );

  node_counter u_node_counter (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .num_nodes_i (num_nodes_i),
    .cmd_i       (cmd),
    .node_vld_i  (node_vld_i),
    .node_idx_o  (node_idx),
    .last_node_o (last_node)
  );

  wh_engine u_wh_engine (
    .clk         (clk),
    .rst_n       (rst_n),
    .wgt_i       (wgt_i),
    .node_feat_i (node_feat_i),
    .wr_en_i     (wh_wr_en),
    .node_idx_i  (node_idx),
    .wh_center_o (wh_center),
    .wh_sel_o    (wh_sel)
  );

  attn_score u_attn_score (
    .clk         (clk),
    .rst_n       (rst_n),
    .attn_i      (attn_i),
    .issue_i     (cmd.score_en),
    .wh_center_i (wh_center),
    .wh_sel_i    (wh_sel),
    .beat_o      (beat)
  );

  aggregator u_aggregator (
    .clk         (clk),
    .rst_n       (rst_n),
    .clear_i     (cmd.clear),
    .beat_i      (beat),
    .feat_o      (feat_o)
  );

endmodule

// File: src/node_counter.sv
`timescale 1ns/1ps

module node_counter (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                start_i,
  input  logic [gat_dim_pkg::NODE_IDX_W:0]    num_nodes_i,
  input  gat_ctrl_pkg::ctrl_cmd_t             cmd_i,
  input  logic                                node_vld_i,
  output logic [gat_dim_pkg::NODE_IDX_W-1:0]  node_idx_o,
  output logic                                last_node_o
);

  logic [gat_dim_pkg::NODE_IDX_W:0]   node_cnt;
  logic [gat_dim_pkg::NODE_IDX_W-1:0] node_idx;
  logic                               step;

  assign step = (cmd_i.load_en && node_vld_i) || cmd_i.score_en;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      node_cnt <= '0;
      node_idx <= '0;
    end else begin
      // Count sampled with an accepted start
      if (cmd_i.clear && start_i) begin
        node_cnt <= num_nodes_i;
      end
      if (cmd_i.clear) begin
        node_idx <= '0;
      end else if (step) begin
        // Wrap so the score phase starts again at node 0
        node_idx <= last_node_o ? '0 : node_idx + 1'b1;
      end
    end
  end

  assign last_node_o = ({1'b0, node_idx} == node_cnt - 1'b1);
  assign node_idx_o  = node_idx;

endmodule

// File: src/wh_engine.sv
`timescale 1ns/1ps

module wh_engine (
  input  logic                                clk,
  input  logic                                rst_n,
  input  gat_dim_pkg::weight_mat_t            wgt_i,
  input  gat_dim_pkg::feat_vec_t              node_feat_i,
  input  logic                                wr_en_i,
  input  logic [gat_dim_pkg::NODE_IDX_W-1:0]  node_idx_i,
  output gat_dim_pkg::wh_vec_t                wh_center_o,
  output gat_dim_pkg::wh_vec_t                wh_sel_o
);

  gat_dim_pkg::wh_vec_t wh_new;
  gat_dim_pkg::wh_vec_t wh_mem [gat_dim_pkg::MAX_NODES];

  // W times h for the strobed node
  always_comb begin : wh_mult
    logic signed [gat_dim_pkg::WH_W-1:0] sum;
    sum    = '0;
    wh_new = '0;
    for (int o = 0; o < gat_dim_pkg::NUM_FEAT_OUT; o++) begin
      sum = '0;
      for (int f = 0; f < gat_dim_pkg::NUM_FEAT_IN; f++) begin
        sum = sum + $signed(wgt_i[o][f]) * $signed(node_feat_i[f]);
      end
      wh_new[o] = sum;
    end
  end

  // Product store with one entry per node of the subgraph
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int n = 0; n < gat_dim_pkg::MAX_NODES; n++) begin
        wh_mem[n] <= '0;
      end
    end else if (wr_en_i) begin
      wh_mem[node_idx_i] <= wh_new;
    end
  end

  assign wh_center_o = wh_mem[0];
  assign wh_sel_o    = wh_mem[node_idx_i];

endmodule

// File: tb/gat_layer_props.sv
`timescale 1ns/1ps

module gat_layer_props (
  input logic clk,
  input logic rst_n,
  input logic start_i,
  input logic busy_o,
  input logic done_o
);

  // Set by an accepted start, cleared by the done that ends the run
  logic run_open;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_open <= 1'b0;
    end else if (start_i && !busy_o) begin
      run_open <= 1'b1;
    end else if (done_o) begin
      run_open <= 1'b0;
    end
  end

  done_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    done_o |=> !done_o)
    else $error("done_o stayed high for more than one cycle");

  done_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
    done_o |-> busy_o)
    else $error("done_o high while busy_o low");

  idle_after_done: assert property (@(posedge clk) disable iff (!rst_n)
    done_o |=> !busy_o)
    else $error("busy_o still high the cycle after done_o");

  done_needs_start: assert property (@(posedge clk) disable iff (!rst_n)
    done_o |-> run_open)
    else $error("done_o without an accepted start_i");

endmodule

bind gat_layer_top gat_layer_props u_props (
  .clk     (clk),
  .rst_n   (rst_n),
  .start_i (start_i),
  .busy_o  (busy_o),
  .done_o  (done_o)
);

// File: tb/tb_gat_layer.sv
`timescale 1ns/1ps

module tb_gat_layer;

  localparam int DONE_TIMEOUT = 40;
  localparam int HOLD_CYCLES  = 4;

  typedef logic [gat_dim_pkg::NODE_IDX_W:0] count_t;

  logic                       clk;
  logic                       rst_n;
  logic                       start_i;
  count_t                     num_nodes_i;
  gat_dim_pkg::weight_mat_t   wgt_i;
  gat_dim_pkg::attn_vec_t     attn_i;
  logic                       node_vld_i;
  gat_dim_pkg::feat_vec_t     node_feat_i;
  logic                       busy_o;
  logic                       done_o;
  gat_dim_pkg::out_vec_t      feat_o;

  gat_dim_pkg::feat_vec_t feats [gat_dim_pkg::MAX_NODES];
  longint                 exp_feat [gat_dim_pkg::NUM_FEAT_OUT];

  integer seed         = 33;
  int     mismatches   = 0;
  int     timeouts     = 0;
  int     other_errors = 0;
  int     neg_scores   = 0;

  gat_layer_top DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .num_nodes_i (num_nodes_i),
    .wgt_i       (wgt_i),
    .attn_i      (attn_i),
    .node_vld_i  (node_vld_i),
    .node_feat_i (node_feat_i),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .feat_o      (feat_o)
  );

  always #20 clk = ~clk;

  // Inputs change 2 ns after the rising edge
  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    assert (actual === expected) else begin
      $display("MISMATCH at %0t: %s expected %0b actual %0b", $time, name, expected, actual);
      mismatches++;
    end
  endtask

  task automatic check_value(input string name, input longint expected, input longint actual);
    assert (actual == expected) else begin
      $display("MISMATCH at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
      mismatches++;
    end
  endtask

  function automatic gat_dim_pkg::data_t rand_data(input bit small_pos);
    logic [31:0] r;
    r = $random(seed);
    if (small_pos) begin
      return gat_dim_pkg::data_t'({2'b00, r[5:0]});
    end
    return gat_dim_pkg::data_t'(r[7:0]);
  endfunction

  // Positive data with negative attention forces negative scores
  task automatic randomize_graph(input bit force_neg);
    for (int o = 0; o < gat_dim_pkg::NUM_FEAT_OUT; o++) begin
      for (int f = 0; f < gat_dim_pkg::NUM_FEAT_IN; f++) begin
        wgt_i[o][f] = rand_data(force_neg);
      end
    end
    for (int i = 0; i < 2*gat_dim_pkg::NUM_FEAT_OUT; i++) begin
      if (force_neg) begin
        attn_i[i] = gat_dim_pkg::data_t'(-8'sd1 - rand_data(1'b1));
      end else begin
        attn_i[i] = rand_data(1'b0);
      end
    end
    for (int n = 0; n < gat_dim_pkg::MAX_NODES; n++) begin
      for (int f = 0; f < gat_dim_pkg::NUM_FEAT_IN; f++) begin
        feats[n][f] = rand_data(force_neg);
      end
    end
  endtask

  // Leaky ReLU with slope 1/8 and flooring
  function automatic longint leaky_relu(input longint x);
    if (x < 0) begin
      return x >>> 3;
    end
    return x;
  endfunction

  task automatic compute_model(input int n);
    longint wh [gat_dim_pkg::MAX_NODES][gat_dim_pkg::NUM_FEAT_OUT];
    longint raw;
    longint score;
    for (int k = 0; k < n; k++) begin
      for (int o = 0; o < gat_dim_pkg::NUM_FEAT_OUT; o++) begin
        wh[k][o] = 0;
        for (int f = 0; f < gat_dim_pkg::NUM_FEAT_IN; f++) begin
          wh[k][o] += longint'(wgt_i[o][f]) * longint'(feats[k][f]);
        end
      end
    end
    for (int o = 0; o < gat_dim_pkg::NUM_FEAT_OUT; o++) begin
      exp_feat[o] = 0;
    end
    for (int k = 0; k < n; k++) begin
      raw = 0;
      for (int i = 0; i < gat_dim_pkg::NUM_FEAT_OUT; i++) begin
        raw += longint'(attn_i[i]) * wh[0][i];
        raw += longint'(attn_i[i+gat_dim_pkg::NUM_FEAT_OUT]) * wh[k][i];
      end
      score = leaky_relu(raw);
      if (score < 0) begin
        neg_scores++;
      end
      for (int o = 0; o < gat_dim_pkg::NUM_FEAT_OUT; o++) begin
        exp_feat[o] += score * wh[k][o];
      end
    end
  endtask

  task automatic strobe_idle(input int count);
    for (int k = 0; k < count; k++) begin
      node_vld_i = 1'b1;
      for (int f = 0; f < gat_dim_pkg::NUM_FEAT_IN; f++) begin
        node_feat_i[f] = rand_data(1'b0);
      end
      tick();
      node_vld_i = 1'b0;
      check_bit("busy_o", 1'b0, busy_o);
      check_bit("done_o", 1'b0, done_o);
    end
  endtask

  // Latency counted in cycles from the last strobe
  task automatic wait_for_done(input int expected_lat);
    int lat;
    lat = 1;
    while (!done_o && lat < DONE_TIMEOUT) begin
      tick();
      lat++;
    end
    if (!done_o) begin
      $display("Timeout: done_o did not rise within %0d cycles of the last node", DONE_TIMEOUT);
      timeouts++;
    end else begin
      check_value("done_o latency", longint'(expected_lat), longint'(lat));
    end
  endtask

  task automatic check_result();
    for (int o = 0; o < gat_dim_pkg::NUM_FEAT_OUT; o++) begin
      check_value($sformatf("feat_o[%0d]", o), exp_feat[o], longint'(feat_o[o]));
    end
  endtask

  task automatic run_graph(input int n, input int gap, input bit stray_start);
    compute_model(n);
    start_i     = 1'b1;
    num_nodes_i = count_t'(n);
    tick();
    start_i = 1'b0;
    check_bit("busy_o", 1'b1, busy_o);
    for (int k = 0; k < n; k++) begin
      repeat (gap) tick();
      node_vld_i  = 1'b1;
      node_feat_i = feats[k];
      // Second start with another count must be ignored in LOAD
      if (stray_start && k == 0) begin
        start_i     = 1'b1;
        num_nodes_i = count_t'(1);
      end
      tick();
      node_vld_i  = 1'b0;
      start_i     = 1'b0;
      num_nodes_i = count_t'(n);
    end
    wait_for_done(n + 2);
    check_result();
    repeat (HOLD_CYCLES) begin
      tick();
      check_result();
    end
  endtask

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    start_i     = 1'b0;
    num_nodes_i = '0;
    wgt_i       = '0;
    attn_i      = '0;
    node_vld_i  = 1'b0;
    node_feat_i = '0;

    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Quiet after reset
    repeat (5) begin
      tick();
      check_bit("busy_o", 1'b0, busy_o);
      check_bit("done_o", 1'b0, done_o);
    end

    // Single node scored against itself as the centre
    randomize_graph(1'b0);
    run_graph(1, 0, 1'b0);

    for (int r = 0; r < 10; r++) begin
      randomize_graph(r % 4 == 0);
      run_graph((r % 2 == 0) ? 4 : 3, 0, 1'b0);
    end

    // Idle strobes and a stray start
    randomize_graph(1'b0);
    strobe_idle(3);
    run_graph(4, 0, 1'b1);

    // Same graph back to back and with gaps
    randomize_graph(1'b0);
    run_graph(4, 0, 1'b0);
    run_graph(4, 2, 1'b0);

    if (neg_scores == 0) begin
      $display("No negative attention score was exercised by the stimulus");
      other_errors++;
    end

    $display("Errors: %0d mismatches, %0d timeouts, %0d other",
             mismatches, timeouts, other_errors);
    if (mismatches + timeouts + other_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
